// File: Makefile
# Verilator build, run, lint and clean for the memory-mapped memory block

VERILATOR   ?= verilator
TOP         ?= tb_mem_map
RTL_TOP     ?= mem_map_top
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
BUILD_FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_MSG    ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then echo "simulation PASS"; \
	else echo "simulation FAIL"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/data_port_router.sv
/*
 * Data port router
 * Decodes data accesses to RAM, test control and timer, steers writes
 * to their target and returns the response one cycle after the grant.
 */
module data_port_router
    import mem_map_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  be_t                       data_be_i,
    input  word_t                     data_addr_i,
    input  word_t                     data_wdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output word_t                     data_rdata_o,

    output logic                      ram_req_o,
    output logic                      ram_we_o,
    output be_t                       ram_be_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output word_t                     ram_wdata_o,
    input  word_t                     ram_rdata_i,

    output logic                      mask_we_o,
    output logic                      cnt_we_o,
    output word_t                     timer_wdata_o,

    output logic                      tests_passed_o,
    output logic                      tests_failed_o
);

    localparam word_t RAM_LEN = word_t'(1) << RAM_ADDR_WIDTH;

    region_e region_d;
    region_e region_q;
    logic    we_q;
    logic    rvalid_q;
    logic    timer_wr;
    logic    ctrl_wr;
    word_t   timer_ofs;
    logic    passed_d;
    logic    failed_d;
    logic    passed_q;
    logic    failed_q;

    // address decode, ram mirrors first
    always_comb begin
        if (!data_req_i) begin
            region_d = NONE;
        end else if (in_ram_map(data_addr_i, RAM_LEN)) begin
            region_d = RAM;
        end else if (data_addr_i >= CTRL_BASE && data_addr_i < CTRL_BASE + CTRL_LEN) begin
            region_d = CTRL;
        end else if (data_addr_i >= TIMER_BASE && data_addr_i < TIMER_BASE + TIMER_LEN) begin
            region_d = TIMER;
        end else begin
            region_d = UNMAP;
        end
    end

    // no back-pressure, every request is taken at once
    assign data_gnt_o = data_req_i;

    assign ram_req_o   = region_d == RAM;
    assign ram_we_o    = ram_req_o && data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_addr_o  = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign ram_wdata_o = data_wdata_i;

    // timer register select by word offset
    assign timer_wr      = (region_d == TIMER) && data_we_i;
    assign timer_ofs     = {data_addr_i[31:2], 2'b00} - TIMER_BASE;
    assign mask_we_o     = timer_wr && (timer_ofs == TIMER_MASK_OFS);
    assign cnt_we_o      = timer_wr && (timer_ofs == TIMER_CNT_OFS);
    assign timer_wdata_o = data_wdata_i;

    assign ctrl_wr  = (region_d == CTRL) && data_we_i;
    assign passed_d = ctrl_wr && (data_wdata_i == TEST_PASS_WORD);
    assign failed_d = ctrl_wr && (data_wdata_i != TEST_PASS_WORD);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            region_q <= NONE;
            we_q     <= 1'b0;
            rvalid_q <= 1'b0;
            passed_q <= 1'b0;
            failed_q <= 1'b0;
        end else begin
            region_q <= region_d;
            we_q     <= data_we_i;
            rvalid_q <= data_req_i;
            // status pulses line up with rvalid
            passed_q <= passed_d;
            failed_q <= failed_d;
        end
    end

    assign data_rvalid_o  = rvalid_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;

    // only ram reads return data, everything else reads as zero
    assign data_rdata_o = (region_q == RAM && !we_q) ? ram_rdata_i : '0;

    no_unmapped_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_gnt_o && data_we_i |-> region_d != UNMAP)
        else $error("write to unmapped address %08x with %08x", data_addr_i, data_wdata_i);

endmodule

// File: hdl/dual_port_ram.sv
/*
 * Dual-port RAM
 * Port A is a read-only fetch port, port B reads and writes with byte
 * enables. Both ports have one cycle of read latency.
 */
module dual_port_ram
    import mem_map_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                      clk_i,

    input  logic                      a_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0] a_addr_i,
    output word_t                     a_rdata_o,

    input  logic                      b_req_i,
    input  logic                      b_we_i,
    input  be_t                       b_be_i,
    input  logic [RAM_ADDR_WIDTH-1:0] b_addr_i,
    input  word_t                     b_wdata_i,
    output word_t                     b_rdata_o
);

    localparam int unsigned WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    word_t mem [WORDS];

    logic [RAM_ADDR_WIDTH-3:0] a_idx;
    logic [RAM_ADDR_WIDTH-3:0] b_idx;

    // word index, byte offset bits dropped
    assign a_idx = a_addr_i[RAM_ADDR_WIDTH-1:2];
    assign b_idx = b_addr_i[RAM_ADDR_WIDTH-1:2];

    // a fetch of a word written in the same cycle sees the old contents
    always_ff @(posedge clk_i) begin
        if (a_req_i) begin
            a_rdata_o <= mem[a_idx];
        end
        if (b_req_i) begin
            if (b_we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (b_be_i[i]) begin
                        mem[b_idx][8*i +: 8] <= b_wdata_i[8*i +: 8];
                    end
                end
            end else begin
                b_rdata_o <= mem[b_idx];
            end
        end
    end

    a_addr_known: assert property (@(posedge clk_i) a_req_i |-> !$isunknown(a_addr_i))
        else $error("fetch port address unknown");

    b_addr_known: assert property (@(posedge clk_i) b_req_i |-> !$isunknown(b_addr_i))
        else $error("data port address unknown");

endmodule

// File: hdl/fetch_port.sv
/*
 * Instruction fetch port
 * Grants every fetch in the same cycle, reads the RAM for addresses in
 * either mirror and answers with rvalid one cycle later.
 */
module fetch_port
    import mem_map_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      instr_req_i,
    input  word_t                     instr_addr_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output word_t                     instr_rdata_o,

    output logic                      ram_req_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    input  word_t                     ram_rdata_i
);

    localparam word_t RAM_LEN = word_t'(1) << RAM_ADDR_WIDTH;

    logic in_ram;
    logic rvalid_q;
    logic in_ram_q;

    assign in_ram      = in_ram_map(instr_addr_i, RAM_LEN);
    assign instr_gnt_o = instr_req_i;

    // upper bits dropped, both mirrors hit the same word
    assign ram_req_o  = instr_req_i && in_ram;
    assign ram_addr_o = instr_addr_i[RAM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            in_ram_q <= 1'b0;
        end else begin
            rvalid_q <= instr_req_i;
            in_ram_q <= instr_req_i && in_ram;
        end
    end

    assign instr_rvalid_o = rvalid_q;
    // fetches outside the ram read as zero
    assign instr_rdata_o  = in_ram_q ? ram_rdata_i : '0;

    gnt_then_rvalid: assert property (
        @(posedge clk_i) disable iff (!rst_ni) instr_gnt_o |=> instr_rvalid_o)
        else $error("instruction grant without rvalid in the next cycle");

endmodule

// File: hdl/mem_map_pkg.sv
/*
 * Memory map package
 * Word types, region encoding and the address map shared by the
 * instruction port, the data port router and the timer.
 */
package mem_map_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;
    typedef logic [4:0]  irq_id_t;

    // ram is mirrored at 0 and at SRAM_BASE
    localparam word_t SRAM_BASE = 32'h1C00_0000;

    // test control, a write reports pass or fail
    localparam word_t CTRL_BASE = 32'h1A10_4000;
    localparam word_t CTRL_LEN  = 32'h0000_1000;

    // countdown timer
    localparam word_t TIMER_BASE     = 32'h1A10_B000;
    localparam word_t TIMER_LEN      = 32'h0000_1000;
    localparam word_t TIMER_MASK_OFS = 32'h0000_0000;
    localparam word_t TIMER_CNT_OFS  = 32'h0000_0004;

    localparam word_t   TEST_PASS_WORD = 32'h0000_F00D;
    localparam irq_id_t TIMER_IRQ_ID   = 5'd3;

    // decoded target of an access, NONE when idle
    typedef enum logic [2:0] {
        RAM,
        CTRL,
        TIMER,
        UNMAP,
        NONE
    } region_e;

    // true when addr hits either ram mirror of length ram_len
    function automatic logic in_ram_map(word_t addr, word_t ram_len);
        logic lo_hit;
        logic hi_hit;
        lo_hit = addr < ram_len;
        hi_hit = (addr >= SRAM_BASE) && (addr < SRAM_BASE + ram_len);
        return lo_hit || hi_hit;
    endfunction

endpackage

// File: hdl/mem_map_top.sv
/*
 * Memory-mapped memory block
 * Instruction and data ports of the core, the shared dual-port RAM,
 * test control outputs and the countdown timer interrupt.
 */
module mem_map_top
    import mem_map_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic    clk_i,
    input  logic    rst_ni,

    input  logic    instr_req_i,
    input  word_t   instr_addr_i,
    output logic    instr_gnt_o,
    output logic    instr_rvalid_o,
    output word_t   instr_rdata_o,

    input  logic    data_req_i,
    input  logic    data_we_i,
    input  be_t     data_be_i,
    input  word_t   data_addr_i,
    input  word_t   data_wdata_i,
    output logic    data_gnt_o,
    output logic    data_rvalid_o,
    output word_t   data_rdata_o,

    input  logic    irq_ack_i,
    input  irq_id_t irq_id_i,
    output logic    irq_o,

    output logic    tests_passed_o,
    output logic    tests_failed_o
);

    // fetch side of the ram
    logic                      fetch_req;
    logic [RAM_ADDR_WIDTH-1:0] fetch_addr;
    word_t                     fetch_rdata;

    // data side of the ram
    logic                      ram_req;
    logic                      ram_we;
    be_t                       ram_be;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    word_t                     ram_wdata;
    word_t                     ram_rdata;

    logic                      mask_we;
    logic                      cnt_we;
    word_t                     timer_wdata;

    fetch_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) fetch_port_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram_req_o      (fetch_req),
        .ram_addr_o     (fetch_addr),
        .ram_rdata_i    (fetch_rdata)
    );

    data_port_router #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) data_port_router_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram_req_o      (ram_req),
        .ram_we_o       (ram_we),
        .ram_be_o       (ram_be),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .mask_we_o      (mask_we),
        .cnt_we_o       (cnt_we),
        .timer_wdata_o  (timer_wdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o)
    );

    dual_port_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) dual_port_ram_i (
        .clk_i     (clk_i),
        .a_req_i   (fetch_req),
        .a_addr_i  (fetch_addr),
        .a_rdata_o (fetch_rdata),
        .b_req_i   (ram_req),
        .b_we_i    (ram_we),
        .b_be_i    (ram_be),
        .b_addr_i  (ram_addr),
        .b_wdata_i (ram_wdata),
        .b_rdata_o (ram_rdata)
    );

    timer_irq_unit timer_irq_unit_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .mask_we_i (mask_we),
        .cnt_we_i  (cnt_we),
        .wdata_i   (timer_wdata),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o)
    );

endmodule

// File: hdl/timer_irq_unit.sv
/*
 * Countdown timer with interrupt
 * A mask and a count register. The count runs down to zero and raises
 * the interrupt when the mask allows it, until the core acknowledges.
 */
module timer_irq_unit
    import mem_map_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    input  logic    mask_we_i,
    input  logic    cnt_we_i,
    input  word_t   wdata_i,

    input  logic    irq_ack_i,
    input  irq_id_t irq_id_i,
    output logic    irq_o
);

    word_t mask_q;
    word_t cnt_q;
    logic  irq_q;
    logic  any_we;
    logic  expire;
    logic  ack;

    assign any_we = mask_we_i || cnt_we_i;
    // count leaves 1 in a cycle without a register write
    assign expire = !any_we && (cnt_q == 32'd1);
    assign ack    = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            if (mask_we_i) begin
                mask_q <= wdata_i;
            end
            if (cnt_we_i) begin
                cnt_q <= wdata_i;
            end else if (!any_we && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // acknowledge wins over a new expiry
            if (ack) begin
                irq_q <= 1'b0;
            end else if (expire && mask_q[TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end
        end
    end

    assign irq_o = irq_q;

    irq_needs_mask: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_o) |-> $past(mask_q[TIMER_IRQ_ID]))
        else $error("timer interrupt raised while masked");

endmodule

// File: project.f
hdl/mem_map_pkg.sv
hdl/dual_port_ram.sv
hdl/fetch_port.sv
hdl/timer_irq_unit.sv
hdl/data_port_router.sv
hdl/mem_map_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_map.sv

// File: testbench/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a number of cycles.
 */
module tb_clock_gen #(
    parameter int unsigned PERIOD     = 100,
    parameter int unsigned RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// File: testbench/tb_mem_map.sv
/*
 * Testbench for the memory-mapped memory block
 * Random RAM traffic on both ports, region reads, test control writes and
 * timer interrupts, checked every cycle against a reference model.
 */
module tb_mem_map;
    import mem_map_pkg::*;

    localparam int unsigned RAM_ADDR_WIDTH = 12;
    localparam word_t       RAM_LEN        = word_t'(1) << RAM_ADDR_WIDTH;
    localparam int unsigned RAM_WORDS      = 2 ** (RAM_ADDR_WIDTH - 2);
    localparam int unsigned RST_CYCLES     = 8;
    localparam int unsigned RAND_OPS       = 600;
    localparam int unsigned REGION_READS   = 16;
    localparam int unsigned V_MAX          = 34;
    // reset, fill, random traffic, region reads, control writes, three timer runs
    localparam int unsigned MAX_CYCLES = RST_CYCLES + RAM_WORDS + RAND_OPS + REGION_READS
        + 16 + 3 * (V_MAX + 12) + 100;

    logic    clk_i;
    logic    rst_ni;
    logic    instr_req_i;
    word_t   instr_addr_i;
    logic    instr_gnt_o;
    logic    instr_rvalid_o;
    word_t   instr_rdata_o;
    logic    data_req_i;
    logic    data_we_i;
    be_t     data_be_i;
    word_t   data_addr_i;
    word_t   data_wdata_i;
    logic    data_gnt_o;
    logic    data_rvalid_o;
    word_t   data_rdata_o;
    logic    irq_ack_i;
    irq_id_t irq_id_i;
    logic    irq_o;
    logic    tests_passed_o;
    logic    tests_failed_o;

    // reference model state, expectations for the next response cycle
    word_t model_mem [RAM_WORDS];
    logic  exp_instr_valid;
    word_t exp_instr_rdata;
    logic  exp_data_valid;
    logic  exp_data_read;
    word_t exp_data_rdata;
    logic  exp_passed;
    logic  exp_failed;
    word_t tmr_mask;
    word_t tmr_cnt;
    logic  tmr_irq;

    integer      seed = 42;
    int unsigned cycle_count = 0;

    tb_clock_gen #(.PERIOD(100), .RST_CYCLES(RST_CYCLES)) clock_gen_i (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    mem_map_top #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) dut_i (.*);

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: test sequence did not end within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // target of an address according to the memory map
    function automatic region_e decode_region(word_t addr);
        if (addr < RAM_LEN || (addr >= SRAM_BASE && addr - SRAM_BASE < RAM_LEN)) begin
            return RAM;
        end
        if (addr >= CTRL_BASE && addr - CTRL_BASE < CTRL_LEN) begin
            return CTRL;
        end
        if (addr >= TIMER_BASE && addr - TIMER_BASE < TIMER_LEN) begin
            return TIMER;
        end
        return UNMAP;
    endfunction

    // random word-aligned address in one of the two ram mirrors
    function automatic word_t ram_address(word_t r);
        return (r[31] ? SRAM_BASE : 32'h0) + (r & (RAM_LEN - 32'd4));
    endfunction

    // initial ram contents mix all address bits
    function automatic word_t fill_word(word_t addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    task automatic check_responses();
        check_value("instr_gnt_o", 32'(instr_req_i), 32'(instr_gnt_o));
        check_value("data_gnt_o", 32'(data_req_i), 32'(data_gnt_o));
        check_value("instr_rvalid_o", 32'(exp_instr_valid), 32'(instr_rvalid_o));
        if (exp_instr_valid) begin
            check_value("instr_rdata_o", exp_instr_rdata, instr_rdata_o);
        end
        check_value("data_rvalid_o", 32'(exp_data_valid), 32'(data_rvalid_o));
        if (exp_data_read) begin
            check_value("data_rdata_o", exp_data_rdata, data_rdata_o);
        end
        check_value("tests_passed_o", 32'(exp_passed), 32'(tests_passed_o));
        check_value("tests_failed_o", 32'(exp_failed), 32'(tests_failed_o));
        check_value("irq_o", 32'(tmr_irq), 32'(irq_o));
    endtask

    // one cycle: check the responses to the last inputs, update the model, drive new inputs
    task automatic tick(logic i_req, word_t i_addr, logic d_req, logic d_we, be_t d_be,
                        word_t d_addr, word_t d_wdata, logic ack, irq_id_t ack_id);
        region_e region;
        word_t   idx;
        word_t   ofs;
        logic    mask_wr;
        logic    cnt_wr;
        @(negedge clk_i);
        check_responses();

        // the fetch sees the ram before this cycle's data write
        exp_instr_valid = i_req;
        idx = (i_addr % RAM_LEN) >> 2;
        exp_instr_rdata = (decode_region(i_addr) == RAM) ? model_mem[idx] : '0;

        region = d_req ? decode_region(d_addr) : NONE;
        idx = (d_addr % RAM_LEN) >> 2;
        exp_data_valid = d_req;
        exp_data_read  = d_req && !d_we;
        exp_data_rdata = (region == RAM) ? model_mem[idx] : '0;
        if (region == RAM && d_we) begin
            for (int b = 0; b < 4; b++) begin
                if (d_be[b]) begin
                    model_mem[idx][8*b +: 8] = d_wdata[8*b +: 8];
                end
            end
        end
        exp_passed = region == CTRL && d_we && d_wdata == TEST_PASS_WORD;
        exp_failed = region == CTRL && d_we && d_wdata != TEST_PASS_WORD;

        // timer, old mask and old count decide the interrupt
        ofs     = (d_addr - TIMER_BASE) & ~32'h3;
        mask_wr = region == TIMER && d_we && ofs == TIMER_MASK_OFS;
        cnt_wr  = region == TIMER && d_we && ofs == TIMER_CNT_OFS;
        if (ack && ack_id == TIMER_IRQ_ID) begin
            tmr_irq = 1'b0;
        end else if (!mask_wr && !cnt_wr && tmr_cnt == 32'd1 && tmr_mask[TIMER_IRQ_ID]) begin
            tmr_irq = 1'b1;
        end
        if (cnt_wr) begin
            tmr_cnt = d_wdata;
        end else if (!mask_wr && tmr_cnt != 32'd0) begin
            tmr_cnt = tmr_cnt - 32'd1;
        end
        if (mask_wr) begin
            tmr_mask = d_wdata;
        end

        instr_req_i  = i_req;
        instr_addr_i = i_addr;
        data_req_i   = d_req;
        data_we_i    = d_we;
        data_be_i    = d_be;
        data_addr_i  = d_addr;
        data_wdata_i = d_wdata;
        irq_ack_i    = ack;
        irq_id_i     = ack_id;
    endtask

    task automatic idle();
        tick(1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic data_write(word_t addr, word_t wdata);
        tick(1'b0, '0, 1'b1, 1'b1, 4'hF, addr, wdata, 1'b0, '0);
    endtask

    // load mask and count, then count the edges after the load until irq_o rises
    task automatic run_timer(word_t mask, word_t count, logic expect_irq);
        int unsigned edges;
        data_write(TIMER_BASE + TIMER_MASK_OFS, mask);
        data_write(TIMER_BASE + TIMER_CNT_OFS, count);
        idle();
        edges = 0;
        while (irq_o !== 1'b1 && edges < count + 4) begin
            idle();
            edges++;
        end
        if (expect_irq) begin
            check_value("edges from load to irq_o", count, 32'(edges));
        end else begin
            check_value("irq_o with mask clear", 32'd0, 32'(irq_o));
        end
    endtask

    initial begin
        word_t r;
        word_t q;
        word_t w;
        word_t d_addr;
        word_t i_addr;
        word_t last_wr;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        exp_instr_valid = 1'b0;
        exp_instr_rdata = '0;
        exp_data_valid  = 1'b0;
        exp_data_read   = 1'b0;
        exp_data_rdata  = '0;
        exp_passed = 1'b0;
        exp_failed = 1'b0;
        tmr_mask   = '0;
        tmr_cnt    = '0;
        tmr_irq    = 1'b0;

        // outputs stay inactive while reset is held
        @(negedge clk_i);
        while (rst_ni !== 1'b1) begin
            check_responses();
            @(negedge clk_i);
        end

        // fill every ram word, alternating mirrors
        for (int i = 0; i < RAM_WORDS; i++) begin
            d_addr = (i[0] ? SRAM_BASE : 32'h0) + (word_t'(i) << 2);
            data_write(d_addr, fill_word(d_addr));
        end

        // random data traffic with fetches of fresh, random and out-of-ram words
        last_wr = '0;
        for (int n = 0; n < RAND_OPS; n++) begin
            r = $random(seed);
            q = $random(seed);
            w = $random(seed);
            d_addr = ram_address(q);
            case (r[1:0])
                2'd0: i_addr = d_addr;
                2'd1: i_addr = last_wr ^ SRAM_BASE;
                2'd2: i_addr = (q[30] ? SRAM_BASE : 32'h0) + RAM_LEN + (w & 32'h00FF_FFFC);
                default: i_addr = ram_address({w[15:0], r[31:16]});
            endcase
            tick(r[4:2] != 3'd0, i_addr, r[6:5] != 2'd0, r[7], r[11:8], d_addr, w, 1'b0, '0);
            if (r[6:5] != 2'd0 && r[7]) begin
                last_wr = d_addr;
            end
        end

        // reads outside the ram return zero
        for (int n = 0; n < REGION_READS; n++) begin
            r = $random(seed);
            q = $random(seed);
            case (r[1:0])
                2'd0: d_addr = CTRL_BASE + (q & (CTRL_LEN - 32'd4));
                2'd1: d_addr = TIMER_BASE + (q & (TIMER_LEN - 32'd4));
                2'd2: d_addr = 32'h2000_0000 + (q & 32'h00FF_FFFC);
                default: d_addr = RAM_LEN + (q & 32'h0000_FFFC);
            endcase
            tick(1'b1, ram_address(q ^ r), 1'b1, 1'b0, 4'hF, d_addr, '0, 1'b0, '0);
        end

        // pass word and other words to test control
        for (int n = 0; n < 6; n++) begin
            q = $random(seed);
            if (n[0] == 1'b0) begin
                q = TEST_PASS_WORD;
            end else if (q == TEST_PASS_WORD) begin
                q = q ^ 32'd1;
            end
            data_write(CTRL_BASE + (word_t'(n) << 2), q);
            idle();
        end

        for (int n = 0; n < 2; n++) begin
            r = $random(seed);
            run_timer(r | (word_t'(1) << TIMER_IRQ_ID), 32'd2 + (r & 32'd31), 1'b1);
            // acknowledge with a wrong id first
            tick(1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 1'b1,
                 TIMER_IRQ_ID ^ {1'b0, r[3:0] | 4'h1});
            idle();
            check_value("irq_o after wrong id", 32'd1, 32'(irq_o));
            tick(1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 1'b1, TIMER_IRQ_ID);
            idle();
            check_value("irq_o after acknowledge", 32'd0, 32'(irq_o));
        end
        r = $random(seed);
        run_timer(r & ~(word_t'(1) << TIMER_IRQ_ID), 32'd2 + (r & 32'd31), 1'b0);

        idle();
        idle();
        $display("No errors");
        $finish;
    end

endmodule
